// File: Bender.yml
package:
  name: lv_wdg

sources:
  - hdl/wdg_pkg.sv
  - hdl/wdg_scan_if.sv
  - hdl/wdg_timer.sv
  - hdl/wdg_scan_fsm.sv
  - hdl/wdg_crc_chk.sv
  - hdl/wdg_link_fsm.sv
  - hdl/lv_wdg_top.sv
  - target: simulation
    files:
      - tb/tb_lv_wdg.sv

// File: files.f
hdl/wdg_pkg.sv
hdl/wdg_scan_if.sv
hdl/wdg_timer.sv
hdl/wdg_scan_fsm.sv
hdl/wdg_crc_chk.sv
hdl/wdg_link_fsm.sv
hdl/lv_wdg_top.sv
tb/tb_lv_wdg.sv

// File: hdl/lv_wdg_top.sv
// Low-voltage watchdog top level.
// Register bank, OWT and SPI sit outside; all inputs share i_clk.
// Interval codes select entries of the package tables at run time.
`default_nettype none

module lv_wdg_top import wdg_pkg::*; #(
    parameter int CNT_W        = WDG_CNT_W,
    parameter int SCAN_REG_NUM = SCAN_TAB_LEN
) (
    input  wire logic                 i_clk,
    input  wire logic                 i_rst_n,
    // register scan
    input  wire logic                 i_scan_en,
    input  wire logic                 i_bist_scan_req,
    output logic                      o_scan_rd_req,
    output logic [REG_AW-1:0]         o_scan_addr,
    input  wire logic                 i_scan_ack,
    input  wire logic [REG_DW-1:0]    i_scan_data,
    input  wire logic [REG_CRC_W-1:0] i_scan_crc,
    output logic                      o_scan_crc_err,
    output logic                      o_bist_scan_ack,
    output logic                      o_bist_scan_err,
    // owt link
    input  wire logic                 i_owt_en,
    input  wire logic                 i_fsm_owt_tx_req,
    input  wire logic                 i_bist_owt_tx_req,
    output logic                      o_owt_tx_req,
    input  wire logic                 i_owt_tx_ack,
    input  wire logic                 i_spi_rst_wdg,
    input  wire logic                 i_owt_rx_rsp,
    output logic                      o_wdg_timeout_err,
    // interval codes
    input  wire logic [1:0]           i_cfg_tmo,
    input  wire logic [1:0]           i_cfg_refresh,
    input  wire logic [1:0]           i_cfg_crc
);

    logic scan_run;
    logic scan_expire;
    logic refresh_run;
    logic refresh_clr;
    logic refresh_expire;
    logic tmo_run;
    logic tmo_clr;
    logic tmo_expire;

    wdg_scan_if u_scan_if ();

    assign u_scan_if.ack  = i_scan_ack;
    assign u_scan_if.data = i_scan_data;
    assign u_scan_if.crc  = i_scan_crc;
    assign o_scan_addr    = u_scan_if.addr;

    //==================================================
    // register scan
    //==================================================
    // scan interval restarts through i_run alone
    wdg_timer #(.CNT_W(CNT_W), .LIMITS(SCAN_TH_TAB)) u_scan_tmr (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_run    (scan_run),
        .i_clr    (1'b0),
        .i_sel    (i_cfg_crc),
        .o_expire (scan_expire)
    );

    wdg_scan_fsm #(.SCAN_REG_NUM(SCAN_REG_NUM)) u_scan_fsm (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_scan_en       (i_scan_en),
        .i_bist_scan_req (i_bist_scan_req),
        .i_tmr_expire    (scan_expire),
        .o_tmr_run       (scan_run),
        .o_scan_rd_req   (o_scan_rd_req),
        .bus             (u_scan_if.scan)
    );

    wdg_crc_chk u_crc_chk (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .bus             (u_scan_if.chk),
        .o_scan_crc_err  (o_scan_crc_err),
        .o_bist_scan_ack (o_bist_scan_ack)
    );

    assign o_bist_scan_err = o_scan_crc_err;

    //==================================================
    // link supervision
    //==================================================
    wdg_timer #(.CNT_W(CNT_W), .LIMITS(REFRESH_TH_TAB)) u_refresh_tmr (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_run    (refresh_run),
        .i_clr    (refresh_clr),
        .i_sel    (i_cfg_refresh),
        .o_expire (refresh_expire)
    );

    wdg_timer #(.CNT_W(CNT_W), .LIMITS(TIMEOUT_TH_TAB)) u_tmo_tmr (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_run    (tmo_run),
        .i_clr    (tmo_clr),
        .i_sel    (i_cfg_tmo),
        .o_expire (tmo_expire)
    );

    wdg_link_fsm u_link_fsm (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_owt_en          (i_owt_en),
        .i_fsm_owt_tx_req  (i_fsm_owt_tx_req),
        .i_bist_owt_tx_req (i_bist_owt_tx_req),
        .i_owt_tx_ack      (i_owt_tx_ack),
        .i_spi_rst_wdg     (i_spi_rst_wdg),
        .i_owt_rx_rsp      (i_owt_rx_rsp),
        .i_refresh_expire  (refresh_expire),
        .i_tmo_expire      (tmo_expire),
        .o_refresh_run     (refresh_run),
        .o_refresh_clr     (refresh_clr),
        .o_tmo_run         (tmo_run),
        .o_tmo_clr         (tmo_clr),
        .o_owt_tx_req      (o_owt_tx_req),
        .o_wdg_timeout_err (o_wdg_timeout_err)
    );

endmodule

`default_nettype wire

// File: hdl/wdg_crc_chk.sv
// CRC-8 check of each scanned register word.
// The message is {1'b1, addr, data}, shifted in msb first.
// Both outputs are registered and appear one cycle after the ack.
`default_nettype none

module wdg_crc_chk import wdg_pkg::*; (
    input  wire logic i_clk,
    input  wire logic i_rst_n,
    wdg_scan_if.chk   bus,
    output logic      o_scan_crc_err,
    output logic      o_bist_scan_ack
);

    localparam int MSG_W = 1 + REG_AW + REG_DW;

    logic [MSG_W-1:0]     crc_msg;
    logic [REG_CRC_W-1:0] crc_calc;

    // marker bit keeps an all-zero word from giving a zero crc
    assign crc_msg = {1'b1, bus.addr, bus.data};

    // unrolled serial lfsr
    always_comb begin
        crc_calc = CRC_INIT;
        for (int i = MSG_W - 1; i >= 0; i--) begin
            if (crc_calc[REG_CRC_W-1] ^ crc_msg[i]) begin
                crc_calc = {crc_calc[REG_CRC_W-2:0], 1'b0} ^ CRC_POLY;
            end else begin
                crc_calc = {crc_calc[REG_CRC_W-2:0], 1'b0};
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_scan_crc_err  <= 1'b0;
            o_bist_scan_ack <= 1'b0;
        end else begin
            o_scan_crc_err  <= bus.ack & (bus.crc != crc_calc);
            o_bist_scan_ack <= bus.ack;
        end
    end

endmodule

`default_nettype wire

// File: hdl/wdg_link_fsm.sv
// OWT link supervisor.
// Transmit request edges are only taken in LINK_IDLE.
// The timeout error is sticky until a response or until i_owt_en drops.
`default_nettype none

module wdg_link_fsm import wdg_pkg::*; (
    input  wire logic i_clk,
    input  wire logic i_rst_n,
    input  wire logic i_owt_en,
    input  wire logic i_fsm_owt_tx_req,
    input  wire logic i_bist_owt_tx_req,
    input  wire logic i_owt_tx_ack,
    input  wire logic i_spi_rst_wdg,
    input  wire logic i_owt_rx_rsp,
    input  wire logic i_refresh_expire,
    input  wire logic i_tmo_expire,
    output logic      o_refresh_run,
    output logic      o_refresh_clr,
    output logic      o_tmo_run,
    output logic      o_tmo_clr,
    output logic      o_owt_tx_req,
    output logic      o_wdg_timeout_err
);

    link_state_e state_q;
    link_state_e state_d;
    logic        fsm_req_q;
    logic        bist_req_q;
    logic        tx_launch;

    //==================================================
    // request edge detect
    //==================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            fsm_req_q  <= 1'b0;
            bist_req_q <= 1'b0;
        end else begin
            fsm_req_q  <= i_fsm_owt_tx_req;
            bist_req_q <= i_bist_owt_tx_req;
        end
    end

    assign tx_launch = (i_fsm_owt_tx_req & ~fsm_req_q) |
                       (i_bist_owt_tx_req & ~bist_req_q);

    //==================================================
    // state machine
    //==================================================
    always_comb begin
        state_d = state_q;
        if (!i_owt_en) begin
            state_d = LINK_OFF;
        end else begin
            case (state_q)
                LINK_OFF: state_d = LINK_IDLE;
                LINK_IDLE: begin
                    if (i_spi_rst_wdg) begin
                        state_d = LINK_WAIT_RSP;
                    end else if (i_refresh_expire || tx_launch) begin
                        state_d = LINK_REQ;
                    end
                end
                LINK_REQ: begin
                    if (i_spi_rst_wdg || i_owt_tx_ack) begin
                        state_d = LINK_WAIT_RSP;
                    end else if (i_tmo_expire) begin
                        state_d = LINK_IDLE;
                    end
                end
                LINK_WAIT_RSP: begin
                    if (i_spi_rst_wdg) begin
                        state_d = LINK_WAIT_RSP;
                    end else if (i_owt_rx_rsp || i_tmo_expire) begin
                        state_d = LINK_IDLE;
                    end
                end
                default: state_d = LINK_OFF;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= LINK_OFF;
        end else begin
            state_q <= state_d;
        end
    end

    // sticky error, response wins over a same-cycle expiry
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wdg_timeout_err <= 1'b0;
        end else if (!i_owt_en || i_owt_rx_rsp) begin
            o_wdg_timeout_err <= 1'b0;
        end else if (i_tmo_expire) begin
            o_wdg_timeout_err <= 1'b1;
        end
    end

    // timer control, gated by enable so they clear at once
    assign o_refresh_run = i_owt_en & (state_q == LINK_IDLE);
    assign o_refresh_clr = i_spi_rst_wdg;
    assign o_tmo_run     = i_owt_en & ((state_q == LINK_REQ) | (state_q == LINK_WAIT_RSP));
    assign o_tmo_clr     = i_owt_rx_rsp;

    assign o_owt_tx_req = (state_q == LINK_REQ);

endmodule

`default_nettype wire

// File: hdl/wdg_pkg.sv
// Widths, interval tables and state encodings shared by the watchdog RTL.
// Interval tables hold cycle counts and must fit in WDG_CNT_W bits.
// The scanner visits SCAN_ADDR_TAB from entry 0 upward.
`default_nettype none

package wdg_pkg;

    //==================================================
    // widths
    //==================================================
    localparam int REG_AW    = 7;
    localparam int REG_DW    = 8;
    localparam int REG_CRC_W = 8;
    localparam int WDG_CNT_W = 8;

    localparam int SCAN_TAB_LEN = 8;

    // one limit per 2-bit config code
    typedef logic [WDG_CNT_W-1:0] cnt_tab_t [4];

    //==================================================
    // tables
    //==================================================
    localparam logic [REG_AW-1:0] SCAN_ADDR_TAB [SCAN_TAB_LEN] = '{
        7'h01, 7'h02, 7'h03, 7'h08, 7'h09, 7'h0A, 7'h0B, 7'h30
    };

    localparam cnt_tab_t SCAN_TH_TAB    = '{8'd16, 8'd32, 8'd64, 8'd128};
    localparam cnt_tab_t REFRESH_TH_TAB = '{8'd20, 8'd40, 8'd80, 8'd160};
    localparam cnt_tab_t TIMEOUT_TH_TAB = '{8'd12, 8'd24, 8'd48, 8'd96};

    // crc-8, msb first, no reflection, no final xor
    localparam logic [REG_CRC_W-1:0] CRC_POLY = 8'h07;
    localparam logic [REG_CRC_W-1:0] CRC_INIT = 8'h00;

    typedef enum logic {
        SCAN_IDLE,
        SCAN_WAIT_ACK
    } scan_state_e;

    typedef enum logic [1:0] {
        LINK_OFF,
        LINK_IDLE,
        LINK_REQ,
        LINK_WAIT_RSP
    } link_state_e;

endpackage

`default_nettype wire

// File: hdl/wdg_scan_fsm.sv
// Background register scanner.
// SCAN_REG_NUM must not exceed SCAN_TAB_LEN; only the first entries are visited.
// A read stays outstanding until acked or both enables drop; no launch meanwhile.
`default_nettype none

module wdg_scan_fsm import wdg_pkg::*; #(
    parameter int SCAN_REG_NUM = SCAN_TAB_LEN
) (
    input  wire logic i_clk,
    input  wire logic i_rst_n,
    input  wire logic i_scan_en,
    input  wire logic i_bist_scan_req,
    input  wire logic i_tmr_expire,
    output logic      o_tmr_run,
    output logic      o_scan_rd_req,
    wdg_scan_if.scan  bus
);

    localparam int PTR_W = (SCAN_REG_NUM > 1) ? $clog2(SCAN_REG_NUM) : 1;

    scan_state_e      state_q;
    scan_state_e      state_d;
    logic [PTR_W-1:0] ptr_q;
    logic             bist_req_q;
    logic             bist_launch;
    logic             launch;
    logic             scan_off;

    //==================================================
    // launch detect
    //==================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bist_req_q <= 1'b0;
        end else begin
            bist_req_q <= i_bist_scan_req;
        end
    end

    assign bist_launch = i_bist_scan_req & ~bist_req_q;
    assign scan_off    = ~i_scan_en & ~i_bist_scan_req;

    // only one read in flight at a time
    assign launch = (state_q == SCAN_IDLE) & (i_tmr_expire | bist_launch);

    //==================================================
    // state machine
    //==================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            SCAN_IDLE: begin
                if (launch) begin
                    state_d = SCAN_WAIT_ACK;
                end
            end
            SCAN_WAIT_ACK: begin
                if (scan_off || bus.ack) begin
                    state_d = SCAN_IDLE;
                end
            end
            default: state_d = SCAN_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= SCAN_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // pointer and address move together at each launch
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ptr_q    <= '0;
            bus.addr <= '0;
        end else if (launch) begin
            bus.addr <= SCAN_ADDR_TAB[ptr_q];
            if (ptr_q == PTR_W'(SCAN_REG_NUM - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= ptr_q + PTR_W'(1);
            end
        end
    end

    assign o_scan_rd_req = (state_q == SCAN_WAIT_ACK);

    // interval restarts after every ack
    assign o_tmr_run = i_scan_en & (state_q == SCAN_IDLE);

endmodule

`default_nettype wire

// File: hdl/wdg_scan_if.sv
// Scan response path between the scanner and the CRC checker.
// ack, data and crc are driven from the register bank side at the top.
`default_nettype none

interface wdg_scan_if import wdg_pkg::*; ();

    // address of the outstanding read, held until the next launch
    logic [REG_AW-1:0]    addr;

    // single-cycle strobe from the register bank
    logic                 ack;
    logic [REG_DW-1:0]    data;
    logic [REG_CRC_W-1:0] crc;

    // scanner owns the address and watches the ack
    modport scan (
        output addr,
        input  ack
    );

    // checker only looks
    modport chk (
        input  addr,
        input  ack,
        input  data,
        input  crc
    );

endinterface

`default_nettype wire

// File: hdl/wdg_timer.sv
// Interval counter with a table-selected limit.
// Limits of 0 or 1 are not supported; the count would never leave zero.
// o_expire is combinational and marks the last count before the wrap.
`default_nettype none

module wdg_timer import wdg_pkg::*; #(
    parameter int       CNT_W  = WDG_CNT_W,
    parameter cnt_tab_t LIMITS = SCAN_TH_TAB
) (
    input  wire logic       i_clk,
    input  wire logic       i_rst_n,
    input  wire logic       i_run,
    input  wire logic       i_clr,
    input  wire logic [1:0] i_sel,
    output logic            o_expire
);

    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] last_cnt;
    logic             active;
    logic             at_last;

    // limit is picked live, so a config change takes effect mid-count
    assign last_cnt = CNT_W'(LIMITS[i_sel]) - CNT_W'(1);

    assign active  = i_run & ~i_clr;
    assign at_last = (cnt_q == last_cnt);

    //==================================================
    // counter
    //==================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_q <= '0;
        end else if (!active) begin
            cnt_q <= '0;
        end else if (at_last) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + CNT_W'(1);
        end
    end

    // owner acts on the same edge the counter wraps
    assign o_expire = active & at_last;

endmodule

`default_nettype wire

// File: tb/tb_lv_wdg.sv
// Self-checking testbench for lv_wdg_top.
// Steps come from tb/wdg_stimulus.txt; register bank and OWT are modelled here.
// Inputs change on the falling edge, outputs are sampled there too.
`default_nettype none

module tb_lv_wdg import wdg_pkg::*;;

    logic i_clk;
    logic i_rst_n;
    logic i_scan_en;
    logic i_bist_scan_req;
    logic i_scan_ack;
    logic [REG_DW-1:0] i_scan_data;
    logic [REG_CRC_W-1:0] i_scan_crc;
    logic i_owt_en;
    logic i_fsm_owt_tx_req;
    logic i_bist_owt_tx_req;
    logic i_owt_tx_ack;
    logic i_spi_rst_wdg;
    logic i_owt_rx_rsp;
    logic [1:0] i_cfg_tmo;
    logic [1:0] i_cfg_refresh;
    logic [1:0] i_cfg_crc;
    logic o_scan_rd_req;
    logic o_scan_crc_err;
    logic o_bist_scan_ack;
    logic o_bist_scan_err;
    logic o_owt_tx_req;
    logic o_wdg_timeout_err;
    logic [REG_AW-1:0] o_scan_addr;

    // intervals and addresses as specified for the device
    int scan_th [4] = '{16, 32, 64, 128};
    int ref_th [4] = '{20, 40, 80, 160};
    int tmo_th [4] = '{12, 24, 48, 96};
    logic [REG_AW-1:0] scan_addrs [8] = '{7'h01, 7'h02, 7'h03, 7'h08,
                                         7'h09, 7'h0A, 7'h0B, 7'h30};

    logic [63:0] kind_a [64];
    logic [7:0] cfg_a [64];
    logic [7:0] data_a [64];
    logic [7:0] dly_a [64];
    logic corrupt_a [64];
    logic exp_a [64];
    int n_steps = 0;
    int exp_ptr = 0;
    logic steps_loaded = 1'b0;
    logic err_model = 1'b0;
    logic req_model = 1'b0;
    logic waiting = 1'b0;

    lv_wdg_top #(.CNT_W(WDG_CNT_W), .SCAN_REG_NUM(8)) i_dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    //==================================================
    // checks
    //==================================================
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic chk_addr(input string name, input logic [REG_AW-1:0] exp,
                            input logic [REG_AW-1:0] got);
        if (got !== exp) fail_run($sformatf("[FAIL] %s exp=%h got=%h", name, exp, got));
    endtask

    task automatic chk_bit(input string name, input logic exp, input logic got);
        if (got !== exp) fail_run($sformatf("[FAIL] %s exp=%h got=%h", name, exp, got));
    endtask

    // ack, crc error and bist error one cycle after the bank ack
    task automatic chk_state_pulse(input logic exp_err);
        chk_bit("o_bist_scan_ack", 1'b1, o_bist_scan_ack);
        chk_bit("o_scan_crc_err", exp_err, o_scan_crc_err);
        chk_bit("o_bist_scan_err", exp_err, o_bist_scan_err);
    endtask

    // crc-8 poly 07, init 0, over {marker, addr, data} msb first
    function automatic logic [7:0] ref_crc8(input logic [6:0] a, input logic [7:0] d);
        logic [15:0] m;
        logic [7:0] r;
        logic fb;
        m = {1'b1, a, d};
        r = 8'h00;
        for (int i = 15; i >= 0; i--) begin
            fb = r[7] ^ m[i];
            r = r << 1;
            if (fb) r = r ^ 8'h07;
        end
        return r;
    endfunction

    //==================================================
    // register bank model
    //==================================================
    task automatic scan_read(input int limit, input logic [7:0] data,
                             input logic corrupt, input logic exp_err, input logic no_ack);
        int n;
        logic [7:0] good;
        n = 0;
        while (o_scan_rd_req !== 1'b1) begin
            if (n >= limit) fail_run("scan read request did not rise in time");
            @(negedge i_clk);
            n++;
        end
        chk_addr("o_scan_addr", scan_addrs[exp_ptr], o_scan_addr);
        exp_ptr = (exp_ptr + 1) % 8;
        if (no_ack) begin
            // back-pressure, then drop both enables
            repeat (4) begin
                @(negedge i_clk);
                chk_bit("o_scan_rd_req", 1'b1, o_scan_rd_req);
            end
            i_bist_scan_req = 1'b0;
            @(negedge i_clk);
            chk_bit("o_scan_rd_req", 1'b0, o_scan_rd_req);
            chk_bit("o_scan_crc_err", 1'b0, o_scan_crc_err);
        end else begin
            good = ref_crc8(scan_addrs[(exp_ptr + 7) % 8], data);
            @(negedge i_clk);
            chk_bit("o_scan_rd_req", 1'b1, o_scan_rd_req);
            @(negedge i_clk);
            i_scan_ack = 1'b1;
            i_scan_data = data;
            i_scan_crc = good ^ {7'b0, corrupt};
            if ((i_scan_crc != good) !== exp_err)
                fail_run("stimulus file expectation disagrees with the reference CRC");
            @(negedge i_clk);
            chk_bit("o_scan_rd_req", 1'b0, o_scan_rd_req);
            chk_state_pulse(i_scan_crc != good);
            i_scan_ack = 1'b0;
            i_scan_data = '0;
            i_scan_crc = '0;
            @(negedge i_clk);
            chk_bit("o_bist_scan_ack", 1'b0, o_bist_scan_ack);
        end
    endtask

    //==================================================
    // OWT model and link step
    //==================================================
    // kind 0 link, 1 spi restart, 2 request without ack
    task automatic link_step(input int kind, input logic [7:0] trig, input logic [7:0] dly,
                             input logic exp_err, input int tmo_lim, input int ref_lim);
        int n;
        int s;
        int r;
        int k_end;
        int rise_lim;
        logic rsp_now;
        n = 0;
        s = (kind == 1) ? 1 : 0;
        r = (dly == 8'hff || kind == 2) ? -1 : 2 + dly;
        // a request edge launches on the next cycle, otherwise the refresh period
        rise_lim = (trig != 8'h00) ? 1 : ref_lim + 4;
        if (kind != 1) begin
            i_fsm_owt_tx_req = trig[0];
            i_bist_owt_tx_req = trig[1];
            while (o_owt_tx_req !== 1'b1) begin
                chk_bit("o_wdg_timeout_err", err_model, o_wdg_timeout_err);
                if (n >= rise_lim) fail_run("OWT transmit request did not rise in time");
                @(negedge i_clk);
                n++;
            end
        end
        if (kind == 2) k_end = dly + 1;
        else if (r < 0) k_end = s + tmo_lim + 2;
        else k_end = ((r > s + tmo_lim) ? r : s + tmo_lim) + 2;
        waiting = 1'b1;
        req_model = (kind != 1);
        for (int k = 0; k <= k_end; k++) begin
            chk_bit("o_owt_tx_req", req_model, o_owt_tx_req);
            chk_bit("o_wdg_timeout_err", err_model, o_wdg_timeout_err);
            i_fsm_owt_tx_req = 1'b0;
            i_bist_owt_tx_req = 1'b0;
            i_spi_rst_wdg = (kind == 1 && k == 0);
            i_owt_tx_ack = (kind == 0 && k == 1);
            rsp_now = (k == r);
            i_owt_rx_rsp = rsp_now;
            if (kind == 2 && k == dly) begin
                i_owt_en = 1'b0;
                err_model = 1'b0;
                req_model = 1'b0;
                waiting = 1'b0;
            end else if (rsp_now) begin
                err_model = 1'b0;
                waiting = 1'b0;
            end else if (waiting && k == s + tmo_lim - 1) begin
                err_model = 1'b1;
                req_model = 1'b0;
                waiting = 1'b0;
            end
            if (kind == 0 && k == 1) req_model = 1'b0;
            if (k < k_end) @(negedge i_clk);
        end
        chk_bit("o_wdg_timeout_err", exp_err, o_wdg_timeout_err);
    endtask

    //==================================================
    // watchdog
    //==================================================
    initial begin
        wait (steps_loaded);
        repeat (n_steps * 200) @(posedge i_clk);
        fail_run("timeout: the test steps did not finish in the allowed time");
    end

    //==================================================
    // main sequence
    //==================================================
    initial begin
        int fd;
        int cnt;
        int t;
        int f;
        int c;
        int d;
        int co;
        int dl;
        int e;
        logic [63:0] kind;
        logic [8*128-1:0] line;
        {i_rst_n, i_scan_en, i_bist_scan_req, i_scan_ack, i_owt_en} = '0;
        {i_fsm_owt_tx_req, i_bist_owt_tx_req, i_owt_tx_ack, i_spi_rst_wdg} = '0;
        i_owt_rx_rsp = 1'b0;
        i_scan_data = '0;
        i_scan_crc = '0;
        {i_cfg_tmo, i_cfg_refresh, i_cfg_crc} = '0;
        fd = $fopen("tb/wdg_stimulus.txt", "r");
        if (fd == 0) fail_run("cannot open the stimulus file");
        while ($fgets(line, fd)) begin
            cnt = $sscanf(line, "%s %h %h %h %h %h %h %h", kind, t, f, c, d, co, dl, e);
            // comment and blank lines do not give eight fields
            if (cnt == 8) begin
                kind_a[n_steps] = kind;
                cfg_a[n_steps] = {2'b0, t[1:0], f[1:0], c[1:0]};
                data_a[n_steps] = d[7:0];
                corrupt_a[n_steps] = co[0];
                dly_a[n_steps] = dl[7:0];
                exp_a[n_steps] = e[0];
                n_steps++;
            end
        end
        $fclose(fd);
        if (n_steps == 0) fail_run("the stimulus file holds no test steps");
        steps_loaded = 1'b1;
        repeat (5) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        for (int i = 0; i < n_steps; i++) begin
            {i_cfg_tmo, i_cfg_refresh, i_cfg_crc} = cfg_a[i][5:0];
            if (kind_a[i] == "scan" || kind_a[i] == "bist") begin
                i_owt_en = 1'b0;
                err_model = 1'b0;
                req_model = 1'b0;
                waiting = 1'b0;
                if (kind_a[i] == "scan") begin
                    i_scan_en = 1'b1;
                    scan_read(scan_th[cfg_a[i][1:0]] + 1, data_a[i], corrupt_a[i],
                              exp_a[i], 1'b0);
                end else begin
                    i_scan_en = 1'b0;
                    i_bist_scan_req = 1'b1;
                    scan_read(3, data_a[i], corrupt_a[i], exp_a[i], dly_a[i] == 8'hff);
                    // a held request must not launch again
                    repeat (20) begin
                        @(negedge i_clk);
                        chk_bit("o_scan_rd_req", 1'b0, o_scan_rd_req);
                    end
                    // low for a full cycle so the next step sees a fresh edge
                    i_bist_scan_req = 1'b0;
                    @(negedge i_clk);
                end
            end else begin
                i_scan_en = 1'b0;
                i_owt_en = 1'b1;
                link_step((kind_a[i] == "spi") ? 1 : (kind_a[i] == "nrsp") ? 2 : 0,
                          data_a[i], dly_a[i], exp_a[i], tmo_th[cfg_a[i][5:4]],
                          ref_th[cfg_a[i][3:2]]);
            end
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/wdg_stimulus.txt
# kind tmo refresh crc data corrupt delay exp_err
# link steps use data as trigger (1 fsm, 2 bist), delay ff means no response
scan 0 0 0 a5 0 00 0
scan 0 0 0 3c 1 00 1
scan 0 0 0 00 0 00 0
scan 0 0 0 ff 0 00 0
scan 0 0 1 5a 1 00 1
scan 0 0 1 81 0 00 0
scan 0 0 1 7e 0 00 0
scan 0 0 1 12 1 00 1
scan 0 0 1 34 0 00 0
bist 0 0 0 c3 0 00 0
bist 0 0 0 99 1 00 1
bist 0 0 0 00 0 ff 0
scan 0 0 0 66 0 00 0
link 0 0 0 00 0 03 0
link 0 0 0 01 0 05 0
link 0 0 0 02 0 02 0
link 1 1 0 00 0 0a 0
link 0 0 0 00 0 ff 1
link 0 0 0 01 0 14 0
spi  0 0 0 00 0 ff 1
spi  0 0 0 00 0 04 0
nrsp 0 0 0 00 0 06 0
nrsp 0 0 0 00 0 10 0
scan 0 0 2 44 0 00 0
scan 0 0 2 ee 1 00 1
